/* src/ccl_pkg.sv */
`default_nettype none

package ccl_pkg;

    // label 0 is background
    localparam int LABEL_BITS = 6;
    typedef logic [LABEL_BITS-1:0] label_t;

    // pixel count of one blob
    localparam int AREA_BITS = 16;
    typedef logic [AREA_BITS-1:0] area_t;

    // one extra bit so a full label set still fits
    typedef logic [LABEL_BITS:0] blob_count_t;

    // incoming pixel coordinates
    typedef logic [10:0] x_coord_t;
    typedef logic [9:0] y_coord_t;

    // default frame, one 16-bit word per row
    localparam int DEFAULT_FRAME_WIDTH = 16;
    localparam int DEFAULT_FRAME_HEIGHT = 6;

    // label capacity, at most 2**LABEL_BITS
    localparam int DEFAULT_MAX_LABELS = 64;

    // smaller blobs are pruned
    localparam int DEFAULT_MIN_AREA = 4;

endpackage

`default_nettype wire

/* src/frame_ram.sv */
`default_nettype none

module frame_ram #(
    parameter type payload_t = logic,
    parameter int DEPTH = 16,
    localparam int ADDR_BITS = $clog2(DEPTH)
) (
    input  wire logic                 clk_in,
    input  wire logic                 wr_en,
    input  wire logic [ADDR_BITS-1:0] wr_addr,
    input  wire payload_t             wr_data,
    input  wire logic [ADDR_BITS-1:0] rd_addr_a,
    input  wire logic [ADDR_BITS-1:0] rd_addr_b,
    output payload_t                  rd_data_a,
    output payload_t                  rd_data_b
);

    payload_t mem [DEPTH];

    // one write port, two registered read slots
    // a read of the address being written returns the old word
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
    end

endmodule

`default_nettype wire

/* src/frame_capture.sv */
`default_nettype none

module frame_capture #(
    parameter int FRAME_WIDTH = ccl_pkg::DEFAULT_FRAME_WIDTH,
    parameter int FRAME_HEIGHT = ccl_pkg::DEFAULT_FRAME_HEIGHT,
    localparam int PIXELS = FRAME_WIDTH * FRAME_HEIGHT,
    localparam int ADDR_BITS = $clog2(PIXELS)
) (
    input  wire logic                 clk_in,
    input  wire logic                 rst_in,
    input  wire logic                 new_frame_in,
    input  wire logic                 valid_in,
    input  wire logic                 mask_in,
    input  wire ccl_pkg::x_coord_t    x_in,
    input  wire ccl_pkg::y_coord_t    y_in,
    input  wire logic [ADDR_BITS-1:0] mask_rd_addr,
    output logic                      mask_rd_data,
    output logic                      frame_stored,
    output logic                      capturing
);

    logic [ADDR_BITS-1:0] wr_addr;
    logic wr_en;
    logic last_pix;

    // raster address, row-major
    assign wr_addr = ADDR_BITS'(y_in * FRAME_WIDTH + x_in);
    // strobes outside a capture are dropped
    assign wr_en = capturing && valid_in;
    assign last_pix = (x_in == FRAME_WIDTH - 1) && (y_in == FRAME_HEIGHT - 1);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            capturing <= 1'b0;
            frame_stored <= 1'b0;
        end else begin
            frame_stored <= 1'b0;
            if (!capturing) begin
                // arm on a new frame
                if (new_frame_in) begin
                    capturing <= 1'b1;
                end
            end else if (valid_in && last_pix) begin
                // last pixel lands this cycle, stored flag follows
                capturing <= 1'b0;
                frame_stored <= 1'b1;
            end
        end
    end

    // mask frame, slot b idle
    frame_ram #(
        .payload_t(logic),
        .DEPTH(PIXELS)
    ) mask_ram (
        .clk_in(clk_in),
        .wr_en(wr_en),
        .wr_addr(wr_addr),
        .wr_data(mask_in),
        .rd_addr_a(mask_rd_addr),
        .rd_addr_b('0),
        .rd_data_a(mask_rd_data),
        .rd_data_b()
    );

endmodule

`default_nettype wire

/* src/raster_labeler.sv */
`default_nettype none

module raster_labeler #(
    parameter int FRAME_WIDTH = ccl_pkg::DEFAULT_FRAME_WIDTH,
    parameter int FRAME_HEIGHT = ccl_pkg::DEFAULT_FRAME_HEIGHT,
    localparam int PIXELS = FRAME_WIDTH * FRAME_HEIGHT,
    localparam int ADDR_BITS = $clog2(PIXELS)
) (
    input  wire logic                 clk_in,
    input  wire logic                 rst_in,
    input  wire logic                 frame_stored,
    input  wire logic                 mask_rd_data,
    input  wire logic                 union_busy,
    output logic [ADDR_BITS-1:0]      mask_rd_addr,
    output logic                      merge_req,
    output ccl_pkg::label_t           merge_a,
    output ccl_pkg::label_t           merge_b,
    output logic                      new_label,
    output ccl_pkg::label_t           new_label_id,
    output logic                      area_inc,
    output ccl_pkg::label_t           area_label,
    output logic                      scan_done,
    output ccl_pkg::label_t           label_count
);

    import ccl_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE, S_MASK, S_NB0, S_NB1, S_NB2, S_WRITE, S_MERGE, S_NEXT
    } state_t;

    state_t state;

    // current pixel
    logic [ADDR_BITS-1:0] pix_addr;
    x_coord_t pix_x;
    y_coord_t pix_y;
    logic last_pix;
    logic has_w;
    logic has_n;
    logic has_ne;

    // neighbour labels, order w nw n ne
    label_t nb [4];
    label_t min_lbl;
    label_t pix_lbl;
    label_t next_lbl;
    logic pick_valid;
    logic [1:0] pick;

    // label frame ports
    logic lbl_wr_en;
    label_t lbl_wr_data;
    logic [ADDR_BITS-1:0] lbl_addr_a;
    logic [ADDR_BITS-1:0] lbl_addr_b;
    label_t lbl_data_a;
    label_t lbl_data_b;

    assign mask_rd_addr = pix_addr;
    // includes the background slot
    assign label_count = next_lbl;

    // off-frame neighbours read as background
    assign has_w = pix_x != '0;
    assign has_n = pix_y != '0;
    assign has_ne = has_n && (pix_x != FRAME_WIDTH - 1);
    assign last_pix = (pix_x == FRAME_WIDTH - 1) && (pix_y == FRAME_HEIGHT - 1);

    // nw and n first, then ne and w
    always_comb begin
        if (state == S_NB0) begin
            lbl_addr_a = pix_addr - ADDR_BITS'(FRAME_WIDTH + 1);
            lbl_addr_b = pix_addr - ADDR_BITS'(FRAME_WIDTH);
        end else begin
            lbl_addr_a = pix_addr - ADDR_BITS'(FRAME_WIDTH - 1);
            lbl_addr_b = pix_addr - 1'b1;
        end
    end

    // smallest non-zero neighbour, 0 if none
    always_comb begin
        min_lbl = '0;
        for (int i = 0; i < 4; i++) begin
            if (nb[i] != '0 && (min_lbl == '0 || nb[i] < min_lbl)) begin
                min_lbl = nb[i];
            end
        end
    end

    // first neighbour still waiting for a merge
    always_comb begin
        pick_valid = 1'b0;
        pick = '0;
        for (int i = 3; i >= 0; i--) begin
            if (nb[i] != '0) begin
                pick_valid = 1'b1;
                pick = 2'(i);
            end
        end
    end

    // background writes 0, foreground the min or a fresh label
    assign lbl_wr_en = (state == S_WRITE) || (state == S_NB0 && !mask_rd_data);
    assign lbl_wr_data = (state != S_WRITE) ? '0 : (min_lbl != '0) ? min_lbl : next_lbl;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= S_IDLE;
            next_lbl <= label_t'(1);
            merge_req <= 1'b0;
            new_label <= 1'b0;
            area_inc <= 1'b0;
            scan_done <= 1'b0;
        end else begin
            merge_req <= 1'b0;
            new_label <= 1'b0;
            area_inc <= 1'b0;
            scan_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (frame_stored) begin
                        pix_addr <= '0;
                        pix_x <= '0;
                        pix_y <= '0;
                        next_lbl <= label_t'(1);
                        state <= S_MASK;
                    end
                end
                S_MASK: begin
                    state <= S_NB0;
                end
                S_NB0: begin
                    // mask bit valid here
                    state <= mask_rd_data ? S_NB1 : S_NEXT;
                end
                S_NB1: begin
                    nb[1] <= (has_w && has_n) ? lbl_data_a : '0;
                    nb[2] <= has_n ? lbl_data_b : '0;
                    state <= S_NB2;
                end
                S_NB2: begin
                    nb[3] <= has_ne ? lbl_data_a : '0;
                    nb[0] <= has_w ? lbl_data_b : '0;
                    state <= S_WRITE;
                end
                S_WRITE: begin
                    pix_lbl <= lbl_wr_data;
                    area_inc <= 1'b1;
                    area_label <= lbl_wr_data;
                    if (min_lbl == '0) begin
                        new_label <= 1'b1;
                        new_label_id <= next_lbl;
                        next_lbl <= next_lbl + 1'b1;
                    end
                    // neighbours already on this label need no merge
                    for (int i = 0; i < 4; i++) begin
                        if (nb[i] == min_lbl) begin
                            nb[i] <= '0;
                        end
                    end
                    state <= S_MERGE;
                end
                S_MERGE: begin
                    // one merge at a time, wait out the union
                    if (!union_busy && !merge_req) begin
                        if (pick_valid) begin
                            merge_req <= 1'b1;
                            merge_a <= pix_lbl;
                            merge_b <= nb[pick];
                            // drop duplicates of the same label
                            for (int i = 0; i < 4; i++) begin
                                if (nb[i] == nb[pick]) begin
                                    nb[i] <= '0;
                                end
                            end
                        end else begin
                            state <= S_NEXT;
                        end
                    end
                end
                S_NEXT: begin
                    if (last_pix) begin
                        scan_done <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        pix_addr <= pix_addr + 1'b1;
                        if (pix_x == FRAME_WIDTH - 1) begin
                            pix_x <= '0;
                            pix_y <= pix_y + 1'b1;
                        end else begin
                            pix_x <= pix_x + 1'b1;
                        end
                        state <= S_MASK;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // provisional label frame
    frame_ram #(
        .payload_t(label_t),
        .DEPTH(PIXELS)
    ) label_ram (
        .clk_in(clk_in),
        .wr_en(lbl_wr_en),
        .wr_addr(pix_addr),
        .wr_data(lbl_wr_data),
        .rd_addr_a(lbl_addr_a),
        .rd_addr_b(lbl_addr_b),
        .rd_data_a(lbl_data_a),
        .rd_data_b(lbl_data_b)
    );

endmodule

`default_nettype wire

/* src/label_union.sv */
`default_nettype none

module label_union #(
    parameter int MAX_LABELS = ccl_pkg::DEFAULT_MAX_LABELS
) (
    input  wire logic            clk_in,
    input  wire logic            rst_in,
    input  wire logic            new_label,
    input  wire ccl_pkg::label_t new_label_id,
    input  wire logic            merge_req,
    input  wire ccl_pkg::label_t merge_a,
    input  wire ccl_pkg::label_t merge_b,
    input  wire logic            find_req,
    input  wire ccl_pkg::label_t find_label,
    output logic                 union_busy,
    output logic                 find_valid,
    output ccl_pkg::label_t      find_root
);

    import ccl_pkg::*;

    typedef enum logic [1:0] {U_IDLE, U_MERGE, U_FIND} state_t;

    state_t state;

    // parent links, a root points at itself
    label_t parent [MAX_LABELS];
    label_t root_a;
    label_t root_b;
    label_t up_a;
    label_t up_b;
    logic link_en;
    label_t link_child;
    label_t link_root;

    assign up_a = parent[root_a];
    assign up_b = parent[root_b];

    // both roots found and distinct, larger goes under smaller
    assign link_en = (state == U_MERGE) && (up_a == root_a) && (up_b == root_b)
                     && (root_a != root_b);
    assign link_child = (root_a > root_b) ? root_a : root_b;
    assign link_root = (root_a > root_b) ? root_b : root_a;

    always_ff @(posedge clk_in) begin
        if (new_label) begin
            parent[new_label_id] <= new_label_id;
        end else if (link_en) begin
            parent[link_child] <= link_root;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= U_IDLE;
            union_busy <= 1'b0;
            find_valid <= 1'b0;
        end else begin
            find_valid <= 1'b0;
            case (state)
                U_IDLE: begin
                    if (merge_req) begin
                        root_a <= merge_a;
                        root_b <= merge_b;
                        union_busy <= 1'b1;
                        state <= U_MERGE;
                    end else if (find_req) begin
                        root_a <= find_label;
                        state <= U_FIND;
                    end
                end
                U_MERGE: begin
                    // one step up per side per cycle
                    if (up_a != root_a || up_b != root_b) begin
                        root_a <= up_a;
                        root_b <= up_b;
                    end else begin
                        union_busy <= 1'b0;
                        state <= U_IDLE;
                    end
                end
                U_FIND: begin
                    if (up_a == root_a) begin
                        find_root <= root_a;
                        find_valid <= 1'b1;
                        state <= U_IDLE;
                    end else begin
                        root_a <= up_a;
                    end
                end
                default: begin
                    state <= U_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/blob_ranker.sv */
`default_nettype none

module blob_ranker #(
    parameter int MAX_LABELS = ccl_pkg::DEFAULT_MAX_LABELS,
    parameter int MIN_AREA = ccl_pkg::DEFAULT_MIN_AREA
) (
    input  wire logic             clk_in,
    input  wire logic             rst_in,
    input  wire logic             frame_start,
    input  wire logic             area_inc,
    input  wire ccl_pkg::label_t  area_label,
    input  wire logic             scan_done,
    input  wire ccl_pkg::label_t  label_count,
    input  wire logic             find_valid,
    input  wire ccl_pkg::label_t  find_root,
    output logic                  find_req,
    output ccl_pkg::label_t       find_label,
    output logic                  result_valid,
    output ccl_pkg::blob_count_t  blob_count,
    output ccl_pkg::area_t        area_first,
    output ccl_pkg::area_t        area_second
);

    import ccl_pkg::*;

    typedef enum logic [2:0] {R_IDLE, R_FIND, R_WAIT, R_SWEEP, R_DONE} state_t;

    state_t state;

    // area per provisional label
    area_t area [MAX_LABELS];
    label_t idx;
    label_t lim;
    area_t cur;
    logic keep;

    // running result, published at the end
    area_t top1;
    area_t top2;
    blob_count_t cnt;

    assign cur = area[idx];
    assign keep = (cur != '0) && (cur >= MIN_AREA);

    always_ff @(posedge clk_in) begin
        if (frame_start) begin
            for (int i = 0; i < MAX_LABELS; i++) begin
                area[i] <= '0;
            end
        end else if (area_inc) begin
            area[area_label] <= area[area_label] + 1'b1;
        end else if (state == R_WAIT && find_valid && find_root != idx) begin
            // fold a child label into its root
            area[find_root] <= area[find_root] + cur;
            area[idx] <= '0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= R_IDLE;
            find_req <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            find_req <= 1'b0;
            result_valid <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (scan_done) begin
                        lim <= label_count;
                        idx <= label_t'(1);
                        state <= R_FIND;
                    end
                end
                R_FIND: begin
                    if (idx >= lim) begin
                        idx <= label_t'(1);
                        cnt <= '0;
                        top1 <= '0;
                        top2 <= '0;
                        state <= R_SWEEP;
                    end else begin
                        find_req <= 1'b1;
                        find_label <= idx;
                        state <= R_WAIT;
                    end
                end
                R_WAIT: begin
                    if (find_valid) begin
                        idx <= idx + 1'b1;
                        state <= R_FIND;
                    end
                end
                R_SWEEP: begin
                    if (idx >= lim) begin
                        state <= R_DONE;
                    end else begin
                        // sorted insert into the top two
                        if (keep) begin
                            cnt <= cnt + 1'b1;
                            if (cur > top1) begin
                                top2 <= top1;
                                top1 <= cur;
                            end else if (cur > top2) begin
                                top2 <= cur;
                            end
                        end
                        idx <= idx + 1'b1;
                    end
                end
                R_DONE: begin
                    result_valid <= 1'b1;
                    blob_count <= cnt;
                    area_first <= top1;
                    area_second <= top2;
                    state <= R_IDLE;
                end
                default: begin
                    state <= R_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/ccl_top.sv */
`default_nettype none

module ccl_top #(
    parameter int FRAME_WIDTH = ccl_pkg::DEFAULT_FRAME_WIDTH,
    parameter int FRAME_HEIGHT = ccl_pkg::DEFAULT_FRAME_HEIGHT,
    parameter int MAX_LABELS = ccl_pkg::DEFAULT_MAX_LABELS,
    parameter int MIN_AREA = ccl_pkg::DEFAULT_MIN_AREA,
    localparam int ADDR_BITS = $clog2(FRAME_WIDTH * FRAME_HEIGHT)
) (
    input  wire logic              clk_in,
    input  wire logic              rst_in,
    input  wire logic              new_frame_in,
    input  wire logic              valid_in,
    input  wire logic              mask_in,
    input  wire ccl_pkg::x_coord_t x_in,
    input  wire ccl_pkg::y_coord_t y_in,
    output logic                   valid_out,
    output logic                   busy_out,
    output ccl_pkg::blob_count_t   blob_count_out,
    output ccl_pkg::area_t         area_out_first,
    output ccl_pkg::area_t         area_out_second
);

    import ccl_pkg::*;

    logic frame_accept;
    logic busy_q;
    logic capturing;
    logic capturing_q;
    logic frame_start;
    logic frame_stored;
    logic [ADDR_BITS-1:0] mask_rd_addr;
    logic mask_rd_data;
    logic union_busy;
    logic merge_req;
    label_t merge_a;
    label_t merge_b;
    logic new_label;
    label_t new_label_id;
    logic area_inc;
    label_t area_label;
    logic scan_done;
    label_t label_count;
    logic find_req;
    label_t find_label;
    logic find_valid;
    label_t find_root;
    logic result_valid;

    // one frame in flight, pulses while busy are dropped
    assign frame_accept = new_frame_in && !busy_out;
    // arm edge of the capture clears the area counters
    assign frame_start = capturing && !capturing_q;
    assign valid_out = result_valid;
    // busy drops with the result pulse
    assign busy_out = busy_q && !result_valid;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy_q <= 1'b0;
            capturing_q <= 1'b0;
        end else begin
            capturing_q <= capturing;
            if (frame_accept) begin
                busy_q <= 1'b1;
            end else if (result_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    frame_capture #(
        .FRAME_WIDTH(FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) capture (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .new_frame_in(frame_accept),
        .valid_in(valid_in),
        .mask_in(mask_in),
        .x_in(x_in),
        .y_in(y_in),
        .mask_rd_addr(mask_rd_addr),
        .mask_rd_data(mask_rd_data),
        .frame_stored(frame_stored),
        .capturing(capturing)
    );

    raster_labeler #(
        .FRAME_WIDTH(FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) labeler (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .frame_stored(frame_stored),
        .mask_rd_data(mask_rd_data),
        .union_busy(union_busy),
        .mask_rd_addr(mask_rd_addr),
        .merge_req(merge_req),
        .merge_a(merge_a),
        .merge_b(merge_b),
        .new_label(new_label),
        .new_label_id(new_label_id),
        .area_inc(area_inc),
        .area_label(area_label),
        .scan_done(scan_done),
        .label_count(label_count)
    );

    label_union #(
        .MAX_LABELS(MAX_LABELS)
    ) union_table (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .new_label(new_label),
        .new_label_id(new_label_id),
        .merge_req(merge_req),
        .merge_a(merge_a),
        .merge_b(merge_b),
        .find_req(find_req),
        .find_label(find_label),
        .union_busy(union_busy),
        .find_valid(find_valid),
        .find_root(find_root)
    );

    blob_ranker #(
        .MAX_LABELS(MAX_LABELS),
        .MIN_AREA(MIN_AREA)
    ) ranker (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .frame_start(frame_start),
        .area_inc(area_inc),
        .area_label(area_label),
        .scan_done(scan_done),
        .label_count(label_count),
        .find_valid(find_valid),
        .find_root(find_root),
        .find_req(find_req),
        .find_label(find_label),
        .result_valid(result_valid),
        .blob_count(blob_count_out),
        .area_first(area_out_first),
        .area_second(area_out_second)
    );

endmodule

`default_nettype wire

/* tests/ccl_tb.sv */
`default_nettype none

module ccl_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import ccl_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_FRAMES = 6;
    // six mask rows then count and the two areas
    localparam int WORDS_PER_FRAME = 9;
    localparam int STIM_WORDS = NUM_FRAMES * WORDS_PER_FRAME;
    localparam int PIXELS = DEFAULT_FRAME_WIDTH * DEFAULT_FRAME_HEIGHT;
    // worst case per frame is every pixel with three full-depth merges plus the fold
    localparam int FRAME_CYCLES = PIXELS * (10 + 3 * 2 * DEFAULT_MAX_LABELS)
                                  + 4 * DEFAULT_MAX_LABELS * DEFAULT_MAX_LABELS;
    localparam longint TIMEOUT_NS = longint'(FRAME_CYCLES) * NUM_FRAMES * CLK_PERIOD;

    logic clk_in;
    logic rst_in;
    logic new_frame_in;
    logic valid_in;
    logic mask_in;
    x_coord_t x_in;
    y_coord_t y_in;
    logic valid_out;
    logic busy_out;
    blob_count_t blob_count_out;
    area_t area_out_first;
    area_t area_out_second;

    logic [15:0] stim [STIM_WORDS];
    logic stim_ok;
    integer seed;
    int errors;
    int checks;
    int cur_frame;

    ccl_top uut (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .new_frame_in(new_frame_in),
        .valid_in(valid_in),
        .mask_in(mask_in),
        .x_in(x_in),
        .y_in(y_in),
        .valid_out(valid_out),
        .busy_out(busy_out),
        .blob_count_out(blob_count_out),
        .area_out_first(area_out_first),
        .area_out_second(area_out_second)
    );

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    // watchdog over the whole run
    initial begin
        #(TIMEOUT_NS);
        errors++;
        $display("Timeout: the design never finished frame %0d within %0d ns",
                 cur_frame, TIMEOUT_NS);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // inputs change and outputs are read just after the edge
    task automatic next_cycle();
        @(posedge clk_in);
        #(DRIVE_DELAY);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%0h, expected 0x%0h (frame %0d, %0t)",
                     name, got, exp, cur_frame, $time);
        end
    endtask

    task automatic check_count(input string name, input blob_count_t got,
                               input blob_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%0h, expected 0x%0h (frame %0d, %0t)",
                     name, got, exp, cur_frame, $time);
        end
    endtask

    task automatic check_area(input string name, input area_t got, input area_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%0h, expected 0x%0h (frame %0d, %0t)",
                     name, got, exp, cur_frame, $time);
        end
    endtask

    // start pulse and pixels with random gaps, then wait for the result
    task automatic run_frame(input int f, input logic stray);
        logic [15:0] row;
        int gap;
        int waited;
        blob_count_t exp_count;
        area_t exp_first;
        area_t exp_second;
        cur_frame = f;
        exp_count = blob_count_t'(stim[f * WORDS_PER_FRAME + 6]);
        exp_first = area_t'(stim[f * WORDS_PER_FRAME + 7]);
        exp_second = area_t'(stim[f * WORDS_PER_FRAME + 8]);
        new_frame_in = 1'b1;
        next_cycle();
        new_frame_in = 1'b0;
        // busy one cycle after the accepted pulse
        check_flag("busy_out", busy_out, 1'b1);
        for (int y = 0; y < DEFAULT_FRAME_HEIGHT; y++) begin
            row = stim[f * WORDS_PER_FRAME + y];
            for (int x = 0; x < DEFAULT_FRAME_WIDTH; x++) begin
                gap = $random(seed) & 3;
                repeat (gap) next_cycle();
                valid_in = 1'b1;
                x_in = x_coord_t'(x);
                y_in = y_coord_t'(y);
                // msb of a row is x = 0
                mask_in = row[DEFAULT_FRAME_WIDTH - 1 - x];
                // stray start in the middle of capture
                new_frame_in = stray && (y == 2) && (x == 0);
                next_cycle();
                valid_in = 1'b0;
                new_frame_in = 1'b0;
                // busy holds through the capture
                check_flag("busy_out", busy_out, 1'b1);
            end
        end
        waited = 0;
        while (valid_out !== 1'b1) begin
            check_flag("busy_out", busy_out, 1'b1);
            // second stray start while labelling runs
            new_frame_in = stray && (waited == 5);
            next_cycle();
            new_frame_in = 1'b0;
            waited++;
        end
        // busy drops together with the result pulse
        check_flag("busy_out", busy_out, 1'b0);
        check_count("blob_count_out", blob_count_out, exp_count);
        check_area("area_out_first", area_out_first, exp_first);
        check_area("area_out_second", area_out_second, exp_second);
        repeat (3) next_cycle();
        // result held with the pulse over and nothing restarted
        check_flag("valid_out", valid_out, 1'b0);
        check_flag("busy_out", busy_out, 1'b0);
        check_count("blob_count_out", blob_count_out, exp_count);
        check_area("area_out_first", area_out_first, exp_first);
        check_area("area_out_second", area_out_second, exp_second);
    endtask

    initial begin
        seed = 32'hf7393e5e;
        errors = 0;
        checks = 0;
        cur_frame = -1;
        rst_in = 1'b1;
        new_frame_in = 1'b0;
        valid_in = 1'b0;
        mask_in = 1'b0;
        x_in = '0;
        y_in = '0;
        $readmemh("tests/ccl_stimulus.txt", stim);
        stim_ok = !$isunknown(stim[STIM_WORDS - 1]);
        repeat (RESET_CYCLES) next_cycle();
        rst_in = 1'b0;
        next_cycle();
        // idle after reset
        check_flag("busy_out", busy_out, 1'b0);
        check_flag("valid_out", valid_out, 1'b0);
        if (stim_ok) begin
            // last frame also gets the stray start pulses
            for (int f = 0; f < NUM_FRAMES; f++) begin
                run_frame(f, f == NUM_FRAMES - 1);
            end
        end else begin
            errors++;
            $display("The stimulus file tests/ccl_stimulus.txt could not be read");
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/ccl_stimulus.txt */
// columns: mask rows y=0..5 (16 bits, msb is x=0), then expected
// blob count, largest area, second area, all in hex, one frame per line
// four rectangles of 6, 8, 4 and 4 pixels
e600 e600 0600 0630 c030 c000 0004 0008 0006
// u-shape of 11, v of 5, comb of 12, all joined through merges
8888 8850 8820 f800 00aa 00ff 0003 000c 000b
// one blob of 5, the rest below the minimum area
f880 0000 000c 2000 1000 0801 0001 0005 0000
// empty frame
0000 0000 0000 0000 0000 0000 0000 0000 0000
// full frame
ffff ffff ffff ffff ffff ffff 0001 0060 0000
// checkerboard, one diagonal blob of 48
aaaa 5555 aaaa 5555 aaaa 5555 0001 0030 0000

/* src.f */
src/ccl_pkg.sv
src/frame_ram.sv
src/frame_capture.sv
src/raster_labeler.sv
src/label_union.sv
src/blob_ranker.sv
src/ccl_top.sv
tests/ccl_tb.sv
